// ==== common/ifetch_macros.svh ====
`ifndef IFETCH_MACROS_SVH
`define IFETCH_MACROS_SVH

// byte address and instruction word width
`define IFETCH_ADDR_W 32

// direct-mapped cache with 8 lines of two words each
`define IC_LINES 8
`define IC_INDEX_W 3
`define IC_OFFSET_W 1

// the low 2 bits select a byte inside the word and are not part of the tag
`define IC_TAG_W (`IFETCH_ADDR_W - `IC_INDEX_W - `IC_OFFSET_W - 2)

// bit positions of the address fields
`define IC_OFFSET_LSB 2
`define IC_INDEX_LSB (`IC_OFFSET_LSB + `IC_OFFSET_W)
`define IC_TAG_LSB (`IC_INDEX_LSB + `IC_INDEX_W)

// fence.i makes older cache contents stale
`define FENCE_I_INST 32'h0000100f

`endif

// ==== common/ifetch_pkg.sv ====
`include "ifetch_macros.svh"

package ifetch_pkg;

  // byte address of a fetch
  typedef logic [`IFETCH_ADDR_W-1:0] addr_t;

  // one instruction word as read from memory
  typedef logic [`IFETCH_ADDR_W-1:0] word_t;

  // line index, pc bits 5 to 3
  typedef logic [`IC_INDEX_W-1:0] ic_index_t;

  // word within a line, pc bit 2
  typedef logic [`IC_OFFSET_W-1:0] ic_offset_t;

  // tag, pc bits 31 to 6
  typedef logic [`IC_TAG_W-1:0] ic_tag_t;

  // refill controller states
  typedef enum logic [1:0]
  {
    IDLE,
    LOOKUP,
    REFILL,
    DELIVER
  } fetch_state_t;

endpackage

// ==== icache/icache_refill_fsm.sv ====
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module icache_refill_fsm
(
  input  logic                 clk,
  input  logic                 rst,
  input  ifetch_pkg::addr_t    pc_i,
  input  logic                 pc_valid_i,
  output logic                 pc_ready_o,
  input  ifetch_pkg::word_t    inst_i,
  output logic                 inst_valid_o,
  input  logic                 inst_ready_i,
  output ifetch_pkg::addr_t    fetch_pc_o,
  input  logic                 hit_i,
  output logic                 refill_start_o,
  input  logic                 last_beat_i,
  output logic                 fill_beat_o,
  output logic                 line_fill_o,
  output logic                 flush_o,
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  input  logic                 wb_ack_i
);

  ifetch_pkg::fetch_state_t state;
  ifetch_pkg::addr_t        fetch_pc;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     deliver_done;

  assign pc_ready_o   = (state == ifetch_pkg::IDLE);
  assign inst_valid_o = (state == ifetch_pkg::DELIVER);
  assign fetch_pc_o   = fetch_pc;
  assign wb_cyc_o     = wb_cyc;
  assign wb_stb_o     = wb_stb;

  assign refill_start_o = (state == ifetch_pkg::LOOKUP) && !hit_i;
  assign fill_beat_o    = wb_cyc && wb_stb && wb_ack_i; // ack only counts while strobing
  assign line_fill_o    = fill_beat_o && last_beat_i;

  assign deliver_done = inst_valid_o && inst_ready_i;
  assign flush_o      = deliver_done && (inst_i == `FENCE_I_INST);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state  <= ifetch_pkg::IDLE;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end
    else
    begin
      case (state)
        ifetch_pkg::IDLE:
        begin
          if (pc_valid_i)
          begin
            state <= ifetch_pkg::LOOKUP;
          end
        end
        ifetch_pkg::LOOKUP:
        begin
          if (hit_i)
          begin
            state <= ifetch_pkg::DELIVER;
          end
          else
          begin
            state  <= ifetch_pkg::REFILL;
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
          end
        end
        ifetch_pkg::REFILL:
        begin
          if (fill_beat_o)
          begin
            wb_stb <= 1'b0; // counter moves to the next beat on this edge
            if (last_beat_i)
            begin
              wb_cyc <= 1'b0;
              state  <= ifetch_pkg::LOOKUP; // line is valid now, so this lookup hits
            end
          end
          else if (!wb_stb)
          begin
            wb_stb <= 1'b1;
          end
        end
        ifetch_pkg::DELIVER:
        begin
          if (deliver_done)
          begin
            state <= ifetch_pkg::IDLE;
          end
        end
        default:
        begin
          state <= ifetch_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (pc_valid_i && pc_ready_o)
    begin
      fetch_pc <= pc_i;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    (pc_valid_i && pc_ready_o) |-> (pc_i[1:0] == 2'b00));

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
    $rose(wb_stb_o) |-> wb_cyc_o);

  a_valid_held: assert property (@(posedge clk) disable iff (rst)
    (inst_valid_o && !inst_ready_i) |=> inst_valid_o);

endmodule

// ==== icache/refill_addr_counter.sv ====
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module refill_addr_counter
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  input  logic                   ack_i,
  input  ifetch_pkg::addr_t      line_pc_i,
  output ifetch_pkg::ic_offset_t beat_o,
  output logic                   last_beat_o,
  output ifetch_pkg::addr_t      wb_adr_o
);

  ifetch_pkg::ic_offset_t beat;

  always_ff @(posedge clk)
  begin
    if (rst || start_i)
    begin
      beat <= '0;
    end
    else if (ack_i)
    begin
      beat <= beat + 1'b1; // wraps back to zero after the last beat
    end
  end

  assign beat_o      = beat;
  assign last_beat_o = (beat == {`IC_OFFSET_W{1'b1}});

  // line base from the pc, word select from the beat count
  assign wb_adr_o = {line_pc_i[`IFETCH_ADDR_W-1:`IC_INDEX_LSB], beat, 2'b00};

  a_no_extra_ack: assert property (@(posedge clk) disable iff (rst)
    (ack_i && last_beat_o) |=> (!ack_i until start_i));

endmodule

// ==== icache/icache_tag_store.sv ====
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module icache_tag_store
(
  input  logic              clk,
  input  logic              rst,
  input  ifetch_pkg::addr_t fetch_pc_i,
  output logic              hit_o,
  input  logic              line_fill_i,
  input  logic              flush_i
);

  ifetch_pkg::ic_tag_t   tags [`IC_LINES];
  logic [`IC_LINES-1:0]  line_valid;
  ifetch_pkg::ic_index_t index;
  ifetch_pkg::ic_tag_t   pc_tag;

  assign index  = fetch_pc_i[`IC_TAG_LSB-1:`IC_INDEX_LSB];
  assign pc_tag = fetch_pc_i[`IFETCH_ADDR_W-1:`IC_TAG_LSB];

  assign hit_o = line_valid[index] && (tags[index] == pc_tag);

  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
    begin
      line_valid <= '0; // fence.i drops the whole cache
    end
    else if (line_fill_i)
    begin
      line_valid[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (line_fill_i)
    begin
      tags[index] <= pc_tag;
    end
  end

  a_fill_flush_excl: assert property (@(posedge clk) disable iff (rst)
    !(line_fill_i && flush_i));

endmodule

// ==== icache/icache_data_store.sv ====
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module icache_data_store
(
  input  logic                   clk,
  input  ifetch_pkg::addr_t      fetch_pc_i,
  input  logic                   wr_en_i,
  input  ifetch_pkg::ic_offset_t wr_beat_i,
  input  ifetch_pkg::word_t      wr_data_i,
  output ifetch_pkg::word_t      inst_o
);

  localparam int WORDS = 1 << `IC_OFFSET_W;

  ifetch_pkg::word_t      lines [`IC_LINES][WORDS];
  ifetch_pkg::ic_index_t  index;
  ifetch_pkg::ic_offset_t offset;

  assign index  = fetch_pc_i[`IC_TAG_LSB-1:`IC_INDEX_LSB];
  assign offset = fetch_pc_i[`IC_INDEX_LSB-1:`IC_OFFSET_LSB];

  // refill writes at the beat offset, not at the pc offset
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      lines[index][wr_beat_i] <= wr_data_i;
    end
  end

  assign inst_o = lines[index][offset];

endmodule

// ==== design/ifetch_top.sv ====
`timescale 1ns/1ps

module ifetch_top
(
  input  logic              clk,
  input  logic              rst,
  input  ifetch_pkg::addr_t pc_i,
  input  logic              pc_valid_i,
  output logic              pc_ready_o,
  output ifetch_pkg::word_t inst_o,
  output ifetch_pkg::addr_t inst_pc_o,
  output logic              inst_valid_o,
  input  logic              inst_ready_i,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output ifetch_pkg::addr_t wb_adr_o,
  input  ifetch_pkg::word_t wb_dat_i,
  input  logic              wb_ack_i
);

  ifetch_pkg::addr_t      fetch_pc;
  ifetch_pkg::word_t      inst;
  ifetch_pkg::ic_offset_t beat;
  logic                   hit;
  logic                   refill_start;
  logic                   last_beat;
  logic                   fill_beat;
  logic                   line_fill;
  logic                   flush;

  assign inst_o    = inst;
  assign inst_pc_o = fetch_pc;

  icache_refill_fsm icache_refill_fsm_inst
  (
    .clk            (clk),
    .rst            (rst),
    .pc_i           (pc_i),
    .pc_valid_i     (pc_valid_i),
    .pc_ready_o     (pc_ready_o),
    .inst_i         (inst),
    .inst_valid_o   (inst_valid_o),
    .inst_ready_i   (inst_ready_i),
    .fetch_pc_o     (fetch_pc),
    .hit_i          (hit),
    .refill_start_o (refill_start),
    .last_beat_i    (last_beat),
    .fill_beat_o    (fill_beat),
    .line_fill_o    (line_fill),
    .flush_o        (flush),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_ack_i       (wb_ack_i)
  );

  refill_addr_counter refill_addr_counter_inst
  (
    .clk         (clk),
    .rst         (rst),
    .start_i     (refill_start),
    .ack_i       (fill_beat),
    .line_pc_i   (fetch_pc),
    .beat_o      (beat),
    .last_beat_o (last_beat),
    .wb_adr_o    (wb_adr_o)
  );

  icache_tag_store icache_tag_store_inst
  (
    .clk         (clk),
    .rst         (rst),
    .fetch_pc_i  (fetch_pc),
    .hit_o       (hit),
    .line_fill_i (line_fill),
    .flush_i     (flush)
  );

  icache_data_store icache_data_store_inst
  (
    .clk        (clk),
    .fetch_pc_i (fetch_pc),
    .wr_en_i    (fill_beat),
    .wr_beat_i  (beat),
    .wr_data_i  (wb_dat_i),
    .inst_o     (inst)
  );

endmodule

// ==== test/wb_inst_mem.sv ====
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module wb_inst_mem
(
  input  logic        clk,
  input  logic        rst,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic [31:0] wb_adr_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  input  logic        clear_count_i,
  output logic [31:0] read_count_o,
  output logic [31:0] first_adr_o,
  output logic [31:0] last_adr_o
);

  logic [1:0] wait_left;

  // every word except the fence one is tied to its own address
  function automatic logic [31:0] mem_word(input logic [31:0] adr);
    if (adr == 32'h0000_0100)
      return `FENCE_I_INST;
    return adr ^ 32'h5a5a_0000;
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      wb_ack_o     <= 1'b0;
      wb_dat_o     <= '0;
      wait_left    <= 2'($urandom_range(3, 0));
      read_count_o <= '0;
      first_adr_o  <= '0;
      last_adr_o   <= '0;
    end
    else
    begin
      if (wb_ack_o)
      begin
        wb_ack_o  <= 1'b0;
        wait_left <= 2'($urandom_range(3, 0)); // fresh wait states for the next beat
      end
      else if (wb_cyc_i && wb_stb_i)
      begin
        if (wait_left == 2'd0)
        begin
          wb_ack_o <= 1'b1;
          wb_dat_o <= mem_word(wb_adr_i);
        end
        else
          wait_left <= wait_left - 2'd1;
      end
      if (clear_count_i)
        read_count_o <= '0;
      else if (wb_ack_o)
      begin
        read_count_o <= read_count_o + 32'd1;
        if (read_count_o == 32'd0)
          first_adr_o <= wb_adr_i;
        last_adr_o <= wb_adr_i; // address is still held while ack is high
      end
    end
  end

endmodule

// ==== test/ifetch_tb.sv ====
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module ifetch_tb;

  localparam logic [31:0] SEED = 32'hcb96_564d;
  localparam int WAIT_LIMIT = 200;

  logic        clk;
  logic        rst;
  logic [31:0] pc;
  logic        pc_valid;
  logic        pc_ready;
  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic        inst_valid;
  logic        inst_ready;
  logic        wb_cyc;
  logic        wb_stb;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat;
  logic        wb_ack;
  logic        count_clear;
  logic [31:0] reads;
  logic [31:0] first_adr;
  logic [31:0] last_adr;

  logic [7:0]  ref_valid; // expected cache contents, line by line
  logic [25:0] ref_tag [8];
  int          errors;
  int          start_errors;
  int          passed;
  int          failed;
  logic        timed_out;

  ifetch_top ifetch_top_inst
  (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc),
    .pc_valid_i   (pc_valid),
    .pc_ready_o   (pc_ready),
    .inst_o       (inst),
    .inst_pc_o    (inst_pc),
    .inst_valid_o (inst_valid),
    .inst_ready_i (inst_ready),
    .wb_cyc_o     (wb_cyc),
    .wb_stb_o     (wb_stb),
    .wb_adr_o     (wb_adr),
    .wb_dat_i     (wb_dat),
    .wb_ack_i     (wb_ack)
  );

  wb_inst_mem wb_inst_mem_inst
  (
    .clk           (clk),
    .rst           (rst),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .wb_adr_i      (wb_adr),
    .wb_dat_o      (wb_dat),
    .wb_ack_o      (wb_ack),
    .clear_count_i (count_clear),
    .read_count_o  (reads),
    .first_adr_o   (first_adr),
    .last_adr_o    (last_adr)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    if (addr == 32'h0000_0100)
      return `FENCE_I_INST;
    return addr ^ 32'h5a5a_0000;
  endfunction

  // a direct-mapped line costs two reads on a miss and none on a hit
  function automatic logic [31:0] predict_reads(input logic [31:0] addr);
    logic [2:0]  idx;
    logic [25:0] tag;
    idx = addr[5:3];
    tag = addr[31:6];
    if (ref_valid[idx] && ref_tag[idx] == tag)
      return 32'd0;
    ref_valid[idx] = 1'b1;
    ref_tag[idx]   = tag;
    return 32'd2;
  endfunction

  task automatic wait_rise(input logic inst_side);
    int cycles;
    cycles = 0;
    while (!(inst_side ? inst_valid : pc_ready) && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!(inst_side ? inst_valid : pc_ready))
    begin
      $display("Timeout: %s did not rise within %0d cycles",
               inst_side ? "inst_valid_o" : "pc_ready_o", WAIT_LIMIT);
      timed_out = 1'b1;
      errors++;
    end
  endtask

  task automatic send_pc(input logic [31:0] addr);
    pc          = addr;
    pc_valid    = 1'b1;
    count_clear = 1'b1; // read count restarts at the acceptance edge
    @(negedge clk);
    pc_valid    = 1'b0;
    count_clear = 1'b0;
  endtask

  task automatic check_delivery(input logic [31:0] addr);
    check_equal("inst_o", inst, expected_word(addr));
    check_equal("inst_pc_o", inst_pc, addr);
    check_equal("read_count_o", reads, predict_reads(addr));
    if (expected_word(addr) == `FENCE_I_INST)
      ref_valid = '0;
  endtask

  task automatic fetch_and_check(input logic [31:0] addr);
    wait_rise(1'b0);
    if (timed_out)
      return;
    send_pc(addr);
    wait_rise(1'b1);
    if (timed_out)
      return;
    check_delivery(addr);
    @(negedge clk); // inst_ready is high, so the word transfers here
  endtask

  task automatic end_test(input string name);
    if (errors == start_errors)
    begin
      passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      failed++;
      $display("test %s: %0d checks failed", name, errors - start_errors);
    end
  endtask

  task automatic reset_state_test();
    start_errors = errors;
    check_equal("pc_ready_o", 32'(pc_ready), 32'd1);
    check_equal("inst_valid_o", 32'(inst_valid), 32'd0);
    check_equal("wb_cyc_o", 32'(wb_cyc), 32'd0);
    check_equal("wb_stb_o", 32'(wb_stb), 32'd0);
    end_test("reset_state");
  endtask

  task automatic cold_miss_hit_test();
    start_errors = errors;
    fetch_and_check(32'h0000_0040);
    check_equal("first_adr_o", first_adr, 32'h0000_0040);
    check_equal("last_adr_o", last_adr, 32'h0000_0044);
    fetch_and_check(32'h0000_0044);
    end_test("cold_miss_hit");
  endtask

  task automatic conflict_eviction_test();
    start_errors = errors;
    fetch_and_check(32'h0000_00c0); // index 0 too, so line 0x40 is evicted first
    fetch_and_check(32'h0000_0040);
    fetch_and_check(32'h0000_0080);
    fetch_and_check(32'h0000_0040);
    end_test("conflict_eviction");
  endtask

  task automatic variable_latency_test();
    int          tag_sel;
    int          off;
    logic [31:0] addr;
    start_errors = errors;
    for (int i = 0; i < 18 && !timed_out; i++)
    begin
      tag_sel = $urandom_range(2, 0);
      off     = $urandom_range(1, 0);
      addr    = 32'h0000_2000 + tag_sel * 64 + (i % 8) * 8 + off * 4;
      fetch_and_check(addr);
    end
    end_test("variable_latency");
  endtask

  task automatic back_pressure_test();
    int          hold;
    logic [31:0] held_inst;
    start_errors = errors;
    hold       = $urandom_range(10, 1);
    inst_ready = 1'b0;
    wait_rise(1'b0);
    if (!timed_out)
    begin
      send_pc(32'h0000_0068);
      wait_rise(1'b1);
    end
    if (!timed_out)
    begin
      check_delivery(32'h0000_0068);
      held_inst = inst;
      repeat (hold)
      begin
        @(negedge clk);
        check_equal("inst_valid_o", 32'(inst_valid), 32'd1);
        check_equal("inst_o", inst, held_inst);
        check_equal("inst_pc_o", inst_pc, 32'h0000_0068);
        check_equal("pc_ready_o", 32'(pc_ready), 32'd0);
        check_equal("wb_cyc_o", 32'(wb_cyc), 32'd0);
      end
      inst_ready = 1'b1;
      @(negedge clk);
      check_equal("inst_valid_o", 32'(inst_valid), 32'd0);
    end
    inst_ready = 1'b1;
    end_test("back_pressure");
  endtask

  task automatic fence_flush_test();
    start_errors = errors;
    fetch_and_check(32'h0000_0040);
    fetch_and_check(32'h0000_0080);
    fetch_and_check(32'h0000_0058);
    fetch_and_check(32'h0000_0058); // warm line, no reads
    fetch_and_check(32'h0000_0100);
    fetch_and_check(32'h0000_0040);
    fetch_and_check(32'h0000_0080);
    fetch_and_check(32'h0000_0058);
    end_test("fence_flush");
  endtask

  initial
  begin
    void'($urandom(SEED));
    rst          = 1'b1;
    pc           = '0;
    pc_valid     = 1'b0;
    inst_ready   = 1'b1;
    count_clear  = 1'b0;
    ref_valid    = '0;
    errors       = 0;
    start_errors = 0;
    passed       = 0;
    failed       = 0;
    timed_out    = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    reset_state_test();
    if (!timed_out)
      cold_miss_hit_test();
    if (!timed_out)
      conflict_eviction_test();
    if (!timed_out)
      variable_latency_test();
    if (!timed_out)
      back_pressure_test();
    if (!timed_out)
      fence_flush_test();
    $display("tests passed %0d, failed %0d, checks failed %0d", passed, failed, errors);
    if (errors == 0 && !timed_out)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+common
common/ifetch_pkg.sv
icache/icache_refill_fsm.sv
icache/refill_addr_counter.sv
icache/icache_tag_store.sv
icache/icache_data_store.sv
design/ifetch_top.sv
test/wb_inst_mem.sv
test/ifetch_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ifetch_tb
FLIST    = flist.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qxF -- "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
